//--- all.f
rtl/alu_cfg_pkg.sv
rtl/alu_op_pkg.sv
rtl/alu_operand_if.sv
rtl/alu_adder_cmp.sv
rtl/alu_shifter.sv
rtl/alu_turbo_simd.sv
rtl/alu_result_sel.sv
rtl/alu_top.sv
sim/tb_alu_top.sv

//--- Bender.yml
package:
  name: alu_turbo

sources:
  - rtl/alu_cfg_pkg.sv
  - rtl/alu_op_pkg.sv
  - rtl/alu_operand_if.sv
  - rtl/alu_adder_cmp.sv
  - rtl/alu_shifter.sv
  - rtl/alu_turbo_simd.sv
  - rtl/alu_result_sel.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - sim/tb_alu_top.sv

//--- sim/tb_alu_top.sv
// --------------------
// testbench for the ALU top level
// reference model written from the operator rules
// LFSR stimulus and directed tests
// --------------------

`timescale 1ns/1ps

module tb_alu_top;

    localparam int EDGE_TIMEOUT = 20;
    // operators are numbered from ADD up to the last turbo op
    localparam int OP_COUNT     = int'(alu_op_pkg::TB_SHUFFLE) + 1;

    logic                clk;
    alu_op_pkg::alu_op_e operator;
    logic [63:0]         op_a;
    logic [63:0]         op_b;
    logic [63:0]         imm;
    logic [63:0]         result;
    logic                branch_res;
    logic                timed_out;
    logic [31:0]         lfsr_state;
    int                  check_cnt = 0;
    int                  err_cnt = 0;
    int                  test_checks = 0;
    int                  test_errs = 0;

    alu_top dut (
        .operator_i   (operator),
        .operand_a_i  (op_a),
        .operand_b_i  (op_b),
        .imm_i        (imm),
        .result_o     (result),
        .branch_res_o (branch_res)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[62:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // --------------------
    // reference model
    // --------------------

    function automatic logic [7:0] lane_model(input alu_op_pkg::alu_op_e op,
                                              input logic [31:0] aw, bw, iw, input int n);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] i;
        logic [7:0] s;
        logic [7:0] d;
        logic [7:0] t;
        a = aw[8*n +: 8];
        b = bw[8*n +: 8];
        i = iw[8*n +: 8];
        s = a + b;
        d = a - b;
        case (op)
            alu_op_pkg::TB_MAX:     return ($signed(a) < $signed(b)) ? b : a;
            alu_op_pkg::TB_ADDS:    return s;
            alu_op_pkg::TB_SUBS:    return d;
            alu_op_pkg::TB_DIV_ADD: return s >> 1;
            alu_op_pkg::TB_DIV_SUB: return d >> 1;
            alu_op_pkg::TB_SB_SAT: begin
                t = ($signed(a) > 63) ? 8'd63 : ($signed(a) < -63) ? 8'hc1 : a;
                return t - b;
            end
            alu_op_pkg::TB_MAXPM: begin
                t = i - b;
                return ($signed(s) < $signed(t)) ? t : s;
            end
            alu_op_pkg::TB_ACCUPP:  return s + i;
            alu_op_pkg::TB_ACCUPM:  return s - i;
            alu_op_pkg::TB_BLEND:   return (a & i) | (b & ~i);
            alu_op_pkg::TB_SCALE: begin
                t = a[7] ? -a : a;
                t = t - (t >> 2);
                return (a[7] ? -t : t) + b;
            end
            alu_op_pkg::TB_SHUFFLE: return (b != 8'h01 && b[3:0] < 4) ? aw[8*b[1:0] +: 8] : 8'h00;
            default:                return 8'h00;
        endcase
    endfunction

    function automatic logic [63:0] result_model(input alu_op_pkg::alu_op_e op,
                                                 input logic [63:0] a, b, i);
        logic [31:0] w;
        logic [63:0] r;
        w = '0;
        r = '0;
        case (op)
            alu_op_pkg::ADD:  r = a + b;
            alu_op_pkg::SUB:  r = a - b;
            alu_op_pkg::ADDW: w = a[31:0] + b[31:0];
            alu_op_pkg::SUBW: w = a[31:0] - b[31:0];
            alu_op_pkg::ANDL: r = a & b;
            alu_op_pkg::ORL:  r = a | b;
            alu_op_pkg::XORL: r = a ^ b;
            alu_op_pkg::SLL:  r = a << b[5:0];
            alu_op_pkg::SRL:  r = a >> b[5:0];
            alu_op_pkg::SRA:  r = $signed(a) >>> b[5:0];
            alu_op_pkg::SLLW: w = a[31:0] << b[4:0];
            alu_op_pkg::SRLW: w = a[31:0] >> b[4:0];
            alu_op_pkg::SRAW: w = $signed(a[31:0]) >>> b[4:0];
            alu_op_pkg::SLTS: r = {63'd0, $signed(a) < $signed(b)};
            alu_op_pkg::SLTU: r = {63'd0, a < b};
            // turbo lanes here and branch compares give zero
            default: begin
                for (int n = 0; n < 4; n++) begin
                    r[8*n +: 8] = lane_model(op, a[31:0], b[31:0], i[31:0], n);
                end
            end
        endcase
        if (op inside {alu_op_pkg::ADDW, alu_op_pkg::SUBW, alu_op_pkg::SLLW,
                       alu_op_pkg::SRLW, alu_op_pkg::SRAW}) r = {{32{w[31]}}, w};
        return r;
    endfunction

    function automatic logic branch_model(input alu_op_pkg::alu_op_e op, input logic [63:0] a, b);
        case (op)
            alu_op_pkg::EQ:  return a == b;
            alu_op_pkg::NE:  return a != b;
            alu_op_pkg::LTS: return $signed(a) < $signed(b);
            alu_op_pkg::LTU: return a < b;
            alu_op_pkg::GES: return $signed(a) >= $signed(b);
            alu_op_pkg::GEU: return a >= b;
            default:         return 1'b1;
        endcase
    endfunction

    // --------------------
    // stimulus and checks
    // --------------------

    // one clock edge, or a timeout after EDGE_TIMEOUT ns
    task automatic wait_edge(input logic rising);
        int waited;
        if (timed_out) return;
        fork
            begin
                if (rising) begin
                    @(posedge clk);
                end else begin
                    @(negedge clk);
                end
            end
            begin
                for (waited = 0; waited < EDGE_TIMEOUT; waited++) begin
                    #1;
                end
                timed_out = 1'b1;
                $display("timeout: no %s clock edge within %0d ns",
                         rising ? "rising" : "falling", EDGE_TIMEOUT);
            end
        join_any
        disable fork;
    endtask

    task automatic check_op(input alu_op_pkg::alu_op_e op, input logic [63:0] a, b, i);
        logic [63:0] exp_res;
        logic        exp_br;
        exp_res = result_model(op, a, b, i);
        exp_br  = branch_model(op, a, b);
        wait_edge(1'b0);
        operator = op;
        op_a     = a;
        op_b     = b;
        imm      = i;
        wait_edge(1'b1);
        if (timed_out) return;
        check_cnt++;
        test_checks++;
        if (result !== exp_res || branch_res !== exp_br) begin
            err_cnt++;
            test_errs++;
            $display("** Error at %0t: %s a=%h b=%h imm=%h got %h/%b expected %h/%b",
                     $time, op.name(), a, b, i, result, branch_res, exp_res, exp_br);
        end
    endtask

    task automatic compare_literal(input string what, input logic [63:0] got, exp);
        if (timed_out) return;
        check_cnt++;
        test_checks++;
        if (got !== exp) begin
            err_cnt++;
            test_errs++;
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // model check plus a value worked out by hand
    task automatic expect_result(input alu_op_pkg::alu_op_e op, input logic [63:0] a, b, i,
                                 input logic [63:0] exp);
        check_op(op, a, b, i);
        compare_literal(op.name(), result, exp);
    endtask

    task automatic expect_branch(input alu_op_pkg::alu_op_e op, input logic [63:0] a, b,
                                 input logic exp);
        check_op(op, a, b, 64'd0);
        compare_literal({op.name(), " flag"}, {63'd0, branch_res}, {63'd0, exp});
    endtask

    task automatic finish_test(input string name);
        $display("%-8s %0d checks, %0d errors", name, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic adder_test();
        expect_result(alu_op_pkg::ADD, 64'h0000_0000_7fff_ffff, 64'd1, 64'd0,
                      64'h0000_0000_8000_0000);
        expect_result(alu_op_pkg::SUB, 64'd0, 64'd1, 64'd0, 64'hffff_ffff_ffff_ffff);
        expect_result(alu_op_pkg::SUB, 64'h0000_0001_0000_0000, 64'd1, 64'd0,
                      64'h0000_0000_ffff_ffff);
        expect_result(alu_op_pkg::ADDW, 64'h1234_5678_7fff_ffff, 64'd1, 64'd0,
                      64'hffff_ffff_8000_0000);
        expect_result(alu_op_pkg::ADDW, 64'hffff_0000_0000_0001, 64'h0000_0001_0000_0002,
                      64'd0, 64'd3);
        expect_result(alu_op_pkg::SUBW, 64'hffff_0000_8000_0000, 64'd1, 64'd0,
                      64'h0000_0000_7fff_ffff);
        expect_result(alu_op_pkg::SUBW, 64'h0000_0001_0000_0000, 64'd1, 64'd0,
                      64'hffff_ffff_ffff_ffff);
        finish_test("adder");
    endtask

    task automatic logic_test();
        logic [63:0] neg;
        logic [63:0] pos;
        neg = 64'h8000_0000_0000_0005;
        pos = 64'h0000_0000_0000_0005;
        expect_result(alu_op_pkg::ANDL, neg, pos, 64'd0, 64'h0000_0000_0000_0005);
        expect_result(alu_op_pkg::ORL,  neg, pos, 64'd0, 64'h8000_0000_0000_0005);
        expect_result(alu_op_pkg::XORL, neg, pos, 64'd0, 64'h8000_0000_0000_0000);
        expect_result(alu_op_pkg::SLTS, neg, pos, 64'd0, 64'd1);
        expect_result(alu_op_pkg::SLTU, neg, pos, 64'd0, 64'd0);
        expect_result(alu_op_pkg::SLTS, pos, neg, 64'd0, 64'd0);
        expect_result(alu_op_pkg::SLTU, pos, neg, 64'd0, 64'd1);
        expect_result(alu_op_pkg::SLTS, pos, pos, 64'd0, 64'd0);
        finish_test("logic");
    endtask

    task automatic branch_test();
        alu_op_pkg::alu_op_e ops[6];
        logic [5:0]          flag_neg_pos;
        logic [5:0]          flag_pos_neg;
        logic [5:0]          flag_equal;
        logic [63:0]         neg;
        logic [63:0]         pos;
        ops = '{alu_op_pkg::EQ, alu_op_pkg::NE, alu_op_pkg::LTS,
                alu_op_pkg::LTU, alu_op_pkg::GES, alu_op_pkg::GEU};
        // bit n is the taken flag for ops[n]
        flag_neg_pos = 6'b100110;
        flag_pos_neg = 6'b011010;
        flag_equal   = 6'b110001;
        neg = 64'h8000_0000_0000_0005;
        pos = 64'h0000_0000_0000_0005;
        for (int n = 0; n < 6; n++) begin
            expect_branch(ops[n], neg, pos, flag_neg_pos[n]);
            expect_branch(ops[n], pos, neg, flag_pos_neg[n]);
            expect_branch(ops[n], pos, pos, flag_equal[n]);
        end
        expect_branch(alu_op_pkg::ADD, neg, pos, 1'b1);
        finish_test("branch");
    endtask

    task automatic shift_test();
        alu_op_pkg::alu_op_e ops[6];
        logic [63:0]         amts[5];
        ops  = '{alu_op_pkg::SLL, alu_op_pkg::SRL, alu_op_pkg::SRA,
                 alu_op_pkg::SLLW, alu_op_pkg::SRLW, alu_op_pkg::SRAW};
        amts = '{64'd0, 64'd1, 64'd31, 64'd32, 64'd63};
        for (int n = 0; n < 6; n++) begin
            for (int k = 0; k < 5; k++) begin
                check_op(ops[n], 64'h8421_0000_8000_f00d, amts[k], 64'd0);
                // amount bits above the shift width set as well
                check_op(ops[n], 64'h7bde_ffff_7fff_0ff2, 64'hffff_ffff_ffff_ffc0 | amts[k],
                         64'd0);
            end
        end
        expect_result(alu_op_pkg::SLL, 64'd1, 64'd63, 64'd0, 64'h8000_0000_0000_0000);
        expect_result(alu_op_pkg::SRL, 64'h8000_0000_0000_0000, 64'd1, 64'd0,
                      64'h4000_0000_0000_0000);
        expect_result(alu_op_pkg::SRL, 64'hffff_ffff_ffff_ffff, 64'd32, 64'd0,
                      64'h0000_0000_ffff_ffff);
        expect_result(alu_op_pkg::SRA, 64'h8000_0000_0000_0000, 64'd63, 64'd0,
                      64'hffff_ffff_ffff_ffff);
        expect_result(alu_op_pkg::SLLW, 64'd1, 64'd32, 64'd0, 64'd1);
        expect_result(alu_op_pkg::SLLW, 64'd1, 64'd31, 64'd0, 64'hffff_ffff_8000_0000);
        expect_result(alu_op_pkg::SRLW, 64'h0000_0000_8000_0000, 64'd63, 64'd0, 64'd1);
        expect_result(alu_op_pkg::SRAW, 64'h0000_0000_8000_0000, 64'd1, 64'd0,
                      64'hffff_ffff_c000_0000);
        finish_test("shift");
    endtask

    task automatic turbo_test();
        logic [7:0]  vals[7];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] i;
        vals = '{8'h80, 8'hc0, 8'hff, 8'h00, 8'h3f, 8'h40, 8'h7f};
        // every pair of lane values meets in lane 0, upper halves hold junk
        for (int code = int'(alu_op_pkg::TB_MAX); code <= int'(alu_op_pkg::TB_SHUFFLE);
             code++) begin
            for (int x = 0; x < 7; x++) begin
                for (int y = 0; y < 7; y++) begin
                    a = {32'hdead_beef, vals[(x+3)%7], vals[(x+2)%7], vals[(x+1)%7], vals[x]};
                    b = {32'hffff_ffff, vals[(y+3)%7], vals[(y+2)%7], vals[(y+1)%7], vals[y]};
                    i = {32'h5a5a_5a5a, vals[(x+y)%7], vals[(x+y+1)%7], vals[(x+y+2)%7],
                         vals[(x+y+3)%7]};
                    check_op(alu_op_pkg::alu_op_e'(code), a, b, i);
                end
            end
        end
        expect_result(alu_op_pkg::TB_MAX, 64'h8000_0000_807f_ff00, 64'h0000_0000_7f80_00ff,
                      64'd0, 64'h0000_0000_7f7f_0000);
        expect_result(alu_op_pkg::TB_DIV_ADD, 64'h0000_0000_0000_807f, 64'h0000_0000_0000_807f,
                      64'd0, 64'h0000_0000_0000_007f);
        expect_result(alu_op_pkg::TB_DIV_SUB, 64'h0000_0000_40ff_0080, 64'h0000_0000_c000_017f,
                      64'd0, 64'h0000_0000_407f_7f00);
        expect_result(alu_op_pkg::TB_SB_SAT, 64'h0000_0000_00c0_807f, 64'h0000_0000_4000_01ff,
                      64'd0, 64'h0000_0000_c0c1_c040);
        expect_result(alu_op_pkg::TB_MAXPM, 64'h0000_0000_0000_7f3f, 64'h0000_0000_0000_0140,
                      64'h0000_0000_0000_007f, 64'h0000_0000_0000_ff7f);
        expect_result(alu_op_pkg::TB_ACCUPM, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0002,
                      64'h0000_0000_0000_0004, 64'h0000_0000_0000_00ff);
        expect_result(alu_op_pkg::TB_BLEND, 64'h0000_0000_1234_5678, 64'h0000_0000_9abc_def0,
                      64'h0000_0000_ff00_ff00, 64'h0000_0000_12bc_56f0);
        expect_result(alu_op_pkg::TB_SCALE, 64'h0000_0000_7fff_4080, 64'h0000_0000_7f00_0100,
                      64'd0, 64'h0000_0000_dfff_31a0);
        // shuffle indices 0 to 3, out of range and the zero key
        expect_result(alu_op_pkg::TB_SHUFFLE, 64'hdead_beef_7f3f_c080, 64'h0000_0000_0001_0203,
                      64'd0, 64'h0000_0000_8000_3f7f);
        expect_result(alu_op_pkg::TB_SHUFFLE, 64'hdead_beef_7f3f_c080, 64'hffff_ffff_1104_ff02,
                      64'd0, 64'h0000_0000_c000_003f);
        expect_result(alu_op_pkg::TB_SHUFFLE, 64'hdead_beef_7f3f_c080, 64'h0000_0000_2131_0020,
                      64'd0, 64'h0000_0000_c0c0_8080);
        finish_test("turbo");
    endtask

    task automatic random_test();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] i;
        for (int n = 0; n < 200; n++) begin
            a = rand_bits(64);
            b = rand_bits(64);
            i = rand_bits(64);
            check_op(alu_op_pkg::alu_op_e'(n % OP_COUNT), a, b, i);
        end
        finish_test("random");
    endtask

    initial begin
        operator   = alu_op_pkg::ADD;
        op_a       = '0;
        op_b       = '0;
        imm        = '0;
        timed_out  = 1'b0;
        lfsr_state = 32'hba86;
        adder_test();
        logic_test();
        branch_test();
        shift_test();
        turbo_test();
        random_test();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/alu_top.sv
// --------------------
// ALU top level
// plain ports onto the operand bundle
// adder/compare, shifter, turbo SIMD and result mux
// --------------------

`timescale 1ns/1ps

module alu_top (
    input  alu_op_pkg::alu_op_e   operator_i,
    input  alu_cfg_pkg::xlen_t    operand_a_i,
    input  alu_cfg_pkg::xlen_t    operand_b_i,
    input  alu_cfg_pkg::xlen_t    imm_i,
    output alu_cfg_pkg::xlen_t    result_o,
    output logic                  branch_res_o
);

    alu_cfg_pkg::xlen_t              sum;
    alu_cfg_pkg::xlen_t              logic_res;
    logic                            less;
    alu_cfg_pkg::xlen_t              shift_res;
    logic [alu_cfg_pkg::WORD_W-1:0]  shift_word_res;
    alu_cfg_pkg::simd_vec_t          simd_res;

    alu_operand_if ops_if ();

    assign ops_if.operator         = operator_i;
    assign ops_if.operand_a.scalar = operand_a_i;
    assign ops_if.operand_b.scalar = operand_b_i;
    assign ops_if.imm.scalar       = imm_i;

    alu_adder_cmp u_adder_cmp (
        .ops_if       (ops_if),
        .sum_o        (sum),
        .logic_res_o  (logic_res),
        .less_o       (less),
        .branch_res_o (branch_res_o)
    );

    alu_shifter u_shifter (
        .ops_if       (ops_if),
        .shift_o      (shift_res),
        .shift_word_o (shift_word_res)
    );

    alu_turbo_simd u_turbo_simd (
        .ops_if (ops_if),
        .simd_o (simd_res)
    );

    alu_result_sel u_result_sel (
        .ops_if       (ops_if),
        .sum_i        (sum),
        .logic_res_i  (logic_res),
        .less_i       (less),
        .shift_i      (shift_res),
        .shift_word_i (shift_word_res),
        .simd_i       (simd_res),
        .result_o     (result_o)
    );

endmodule

//--- rtl/alu_result_sel.sv
// --------------------
// result multiplexer
// word results sign-extended from bit 31
// turbo and set-less-than results zero-extended
// --------------------

`timescale 1ns/1ps

module alu_result_sel (
    alu_operand_if.unit                     ops_if,
    input  alu_cfg_pkg::xlen_t              sum_i,
    input  alu_cfg_pkg::xlen_t              logic_res_i,
    input  logic                            less_i,
    input  alu_cfg_pkg::xlen_t              shift_i,
    input  logic [alu_cfg_pkg::WORD_W-1:0]  shift_word_i,
    input  alu_cfg_pkg::simd_vec_t          simd_i,
    output alu_cfg_pkg::xlen_t              result_o
);

    logic [alu_cfg_pkg::WORD_W-1:0] word_res;

    // word adds take the low half of the sum, word shifts their own path
    assign word_res = (ops_if.operator inside {alu_op_pkg::ADDW, alu_op_pkg::SUBW}) ?
                      sum_i[alu_cfg_pkg::WORD_W-1:0] : shift_word_i;

    always_comb begin
        result_o = '0;

        if (alu_op_pkg::is_word_op(ops_if.operator)) begin
            result_o = {{(alu_cfg_pkg::XLEN - alu_cfg_pkg::WORD_W){word_res[alu_cfg_pkg::WORD_W-1]}},
                        word_res};
        end else if (alu_op_pkg::is_turbo_op(ops_if.operator)) begin
            result_o = {{(alu_cfg_pkg::XLEN - alu_cfg_pkg::SIMD_W){1'b0}}, simd_i};
        end else begin
            unique case (ops_if.operator)
                alu_op_pkg::ADD, alu_op_pkg::SUB: begin
                    result_o = sum_i;
                end
                alu_op_pkg::ANDL, alu_op_pkg::ORL, alu_op_pkg::XORL: begin
                    result_o = logic_res_i;
                end
                alu_op_pkg::SLL, alu_op_pkg::SRL, alu_op_pkg::SRA: begin
                    result_o = shift_i;
                end
                alu_op_pkg::SLTS, alu_op_pkg::SLTU: begin
                    result_o = {{(alu_cfg_pkg::XLEN - 1){1'b0}}, less_i};
                end
                // branch compares only drive the branch flag
                default: begin
                    result_o = '0;
                end
            endcase
        end
    end

endmodule

//--- rtl/alu_turbo_simd.sv
// --------------------
// turbo SIMD unit, four signed 8-bit lanes
// max, wrapping add and sub, halving, saturate-subtract
// max-plus-minus, accumulate, blend, scale
// byte shuffle over the low word of operand a
// --------------------

`timescale 1ns/1ps

module alu_turbo_simd (
    alu_operand_if.unit             ops_if,
    output alu_cfg_pkg::simd_vec_t  simd_o
);

    alu_cfg_pkg::simd_vec_t vec_a;
    alu_cfg_pkg::simd_vec_t vec_b;
    alu_cfg_pkg::simd_vec_t vec_imm;

    assign vec_a   = ops_if.operand_a.simd.lanes;
    assign vec_b   = ops_if.operand_b.simd.lanes;
    assign vec_imm = ops_if.imm.simd.lanes;

    for (genvar i = 0; i < alu_cfg_pkg::LANES; i++) begin : g_lane

        alu_cfg_pkg::lane_t                   la;
        alu_cfg_pkg::lane_t                   lb;
        alu_cfg_pkg::lane_t                   li;
        alu_cfg_pkg::lane_t                   add_r;
        alu_cfg_pkg::lane_t                   sub_r;
        alu_cfg_pkg::lane_t                   max_r;
        alu_cfg_pkg::lane_t                   sat_a;
        alu_cfg_pkg::lane_t                   imm_sub;
        alu_cfg_pkg::lane_t                   maxpm_r;
        alu_cfg_pkg::lane_t                   mag;
        alu_cfg_pkg::lane_t                   scaled;
        alu_cfg_pkg::lane_t                   shfl_r;
        alu_cfg_pkg::lane_t                   lane_res;
        logic [alu_cfg_pkg::SHFL_IDX_W-1:0]   shfl_idx;

        assign la = vec_a[i];
        assign lb = vec_b[i];
        assign li = vec_imm[i];

        // all arithmetic wraps modulo 256
        assign add_r = la + lb;
        assign sub_r = la - lb;
        assign max_r = ($signed(la) < $signed(lb)) ? lb : la;

        // clamp a to the symmetric limit before subtracting b
        assign sat_a = (la > alu_cfg_pkg::SAT_LIMIT)  ? alu_cfg_pkg::lane_t'(alu_cfg_pkg::SAT_LIMIT) :
                       (la < -alu_cfg_pkg::SAT_LIMIT) ? alu_cfg_pkg::lane_t'(-alu_cfg_pkg::SAT_LIMIT) :
                       la;

        // max of a+b and imm-b
        assign imm_sub = li - lb;
        assign maxpm_r = ($signed(add_r) < $signed(imm_sub)) ? imm_sub : add_r;

        // magnitude times 3/4, sign restored, then b added
        assign mag    = la[alu_cfg_pkg::LANE_W-1] ? -la : la;
        assign scaled = mag - (mag >> 2);

        // out-of-range index or the zero key clears the lane
        assign shfl_idx = lb[alu_cfg_pkg::SHFL_IDX_W-1:0];
        always_comb begin
            shfl_r = '0;
            if (lb != alu_cfg_pkg::lane_t'(alu_cfg_pkg::SHFL_ZERO_KEY) &&
                shfl_idx < alu_cfg_pkg::LANES) begin
                shfl_r = vec_a[shfl_idx[$clog2(alu_cfg_pkg::LANES)-1:0]];
            end
        end

        // lane result by operator
        always_comb begin
            unique case (ops_if.operator)
                alu_op_pkg::TB_MAX:     lane_res = max_r;
                alu_op_pkg::TB_ADDS:    lane_res = add_r;
                alu_op_pkg::TB_SUBS:    lane_res = sub_r;
                alu_op_pkg::TB_DIV_ADD: lane_res = $unsigned(add_r) >> 1;
                alu_op_pkg::TB_DIV_SUB: lane_res = $unsigned(sub_r) >> 1;
                alu_op_pkg::TB_SB_SAT:  lane_res = sat_a - lb;
                alu_op_pkg::TB_MAXPM:   lane_res = maxpm_r;
                alu_op_pkg::TB_ACCUPP:  lane_res = add_r + li;
                alu_op_pkg::TB_ACCUPM:  lane_res = add_r - li;
                alu_op_pkg::TB_BLEND:   lane_res = (la & li) | (lb & ~li);
                alu_op_pkg::TB_SCALE: begin
                    lane_res = (la[alu_cfg_pkg::LANE_W-1] ? -scaled : scaled) + lb;
                end
                alu_op_pkg::TB_SHUFFLE: lane_res = shfl_r;
                default:                lane_res = '0;
            endcase
        end

        assign simd_o[i] = lane_res;
    end

endmodule

//--- rtl/alu_shifter.sv
// --------------------
// 64-bit and word shifter
// left shifts reuse the right shifter on reversed bits
// --------------------

`timescale 1ns/1ps

module alu_shifter (
    alu_operand_if.unit                  ops_if,
    output alu_cfg_pkg::xlen_t           shift_o,
    output logic [alu_cfg_pkg::WORD_W-1:0] shift_word_o
);

    alu_cfg_pkg::xlen_t                    op_a;
    alu_cfg_pkg::xlen_t                    op_a_rev;
    logic [alu_cfg_pkg::WORD_W-1:0]        op_a_rev32;
    logic                                  shift_left;
    logic                                  shift_arith;
    logic [alu_cfg_pkg::SHAMT_W-1:0]       shamt;
    logic [alu_cfg_pkg::SHAMT_WORD_W-1:0]  shamt_word;
    logic [alu_cfg_pkg::XLEN:0]            shift_in;
    logic [alu_cfg_pkg::WORD_W:0]          shift_in32;
    logic [alu_cfg_pkg::XLEN:0]            right_res;
    logic [alu_cfg_pkg::WORD_W:0]          right_res32;
    alu_cfg_pkg::xlen_t                    left_res;
    logic [alu_cfg_pkg::WORD_W-1:0]        left_res32;

    assign op_a        = ops_if.operand_a.scalar;
    assign shamt       = ops_if.operand_b.scalar[alu_cfg_pkg::SHAMT_W-1:0];
    assign shamt_word  = ops_if.operand_b.scalar[alu_cfg_pkg::SHAMT_WORD_W-1:0];
    assign shift_left  = ops_if.operator inside {alu_op_pkg::SLL, alu_op_pkg::SLLW};
    assign shift_arith = ops_if.operator inside {alu_op_pkg::SRA, alu_op_pkg::SRAW};

    // bit reversal of the operand before and of the result after
    for (genvar k = 0; k < alu_cfg_pkg::XLEN; k++) begin : g_rev64
        assign op_a_rev[k] = op_a[alu_cfg_pkg::XLEN-1-k];
        assign left_res[k] = right_res[alu_cfg_pkg::XLEN-1-k];
    end

    for (genvar k = 0; k < alu_cfg_pkg::WORD_W; k++) begin : g_rev32
        assign op_a_rev32[k] = op_a[alu_cfg_pkg::WORD_W-1-k];
        assign left_res32[k] = right_res32[alu_cfg_pkg::WORD_W-1-k];
    end

    // fill bit is the sign only for arithmetic shifts
    assign shift_in   = {shift_arith & op_a[alu_cfg_pkg::XLEN-1],
                         shift_left ? op_a_rev : op_a};
    assign shift_in32 = {shift_arith & op_a[alu_cfg_pkg::WORD_W-1],
                         shift_left ? op_a_rev32 : op_a[alu_cfg_pkg::WORD_W-1:0]};

    assign right_res   = $unsigned($signed(shift_in) >>> shamt);
    assign right_res32 = $unsigned($signed(shift_in32) >>> shamt_word);

    assign shift_o      = shift_left ? left_res : right_res[alu_cfg_pkg::XLEN-1:0];
    assign shift_word_o = shift_left ? left_res32 : right_res32[alu_cfg_pkg::WORD_W-1:0];

endmodule

//--- rtl/alu_adder_cmp.sv
// --------------------
// 64-bit adder with carry-in trick
// AND, OR and XOR of the operands
// signed and unsigned less-than
// branch resolution from zero flag and less
// --------------------

`timescale 1ns/1ps

module alu_adder_cmp (
    alu_operand_if.unit         ops_if,
    output alu_cfg_pkg::xlen_t  sum_o,
    output alu_cfg_pkg::xlen_t  logic_res_o,
    output logic                less_o,
    output logic                branch_res_o
);

    alu_cfg_pkg::xlen_t            op_a;
    alu_cfg_pkg::xlen_t            op_b;
    logic                          negate_b;
    logic [alu_cfg_pkg::XLEN:0]    adder_in_a;
    logic [alu_cfg_pkg::XLEN:0]    adder_in_b;
    logic [alu_cfg_pkg::XLEN:0]    adder_ext;
    logic                          zero_flag;
    logic                          sgn;

    assign op_a = ops_if.operand_a.scalar;
    assign op_b = ops_if.operand_b.scalar;

    // --------------------
    // adder
    // --------------------

    // subtract for SUB and for the equality compares
    assign negate_b = ops_if.operator inside {alu_op_pkg::SUB, alu_op_pkg::SUBW,
                                              alu_op_pkg::EQ, alu_op_pkg::NE};

    // extra lsb carries the +1 of the two's complement
    assign adder_in_a = {op_a, 1'b1};
    assign adder_in_b = {op_b, 1'b0} ^ {(alu_cfg_pkg::XLEN + 1){negate_b}};
    assign adder_ext  = adder_in_a + adder_in_b;
    assign sum_o      = adder_ext[alu_cfg_pkg::XLEN:1];
    assign zero_flag  = ~|sum_o;

    // --------------------
    // logic ops
    // --------------------

    always_comb begin
        unique case (ops_if.operator)
            alu_op_pkg::ANDL: logic_res_o = op_a & op_b;
            alu_op_pkg::ORL:  logic_res_o = op_a | op_b;
            alu_op_pkg::XORL: logic_res_o = op_a ^ op_b;
            default:          logic_res_o = '0;
        endcase
    end

    // --------------------
    // compare
    // --------------------

    // one extra sign bit turns the compare signed or unsigned
    assign sgn    = alu_op_pkg::is_signed_cmp(ops_if.operator);
    assign less_o = $signed({sgn & op_a[alu_cfg_pkg::XLEN-1], op_a}) <
                    $signed({sgn & op_b[alu_cfg_pkg::XLEN-1], op_b});

    // taken by default for non-branch operators
    always_comb begin
        unique case (ops_if.operator)
            alu_op_pkg::EQ:                  branch_res_o = zero_flag;
            alu_op_pkg::NE:                  branch_res_o = ~zero_flag;
            alu_op_pkg::LTS, alu_op_pkg::LTU: branch_res_o = less_o;
            alu_op_pkg::GES, alu_op_pkg::GEU: branch_res_o = ~less_o;
            default:                         branch_res_o = 1'b1;
        endcase
    end

endmodule

//--- rtl/alu_operand_if.sv
// --------------------
// operator and operand bundle
// fanned out from the top level to the ALU units
// --------------------

`timescale 1ns/1ps

interface alu_operand_if;

    alu_op_pkg::alu_op_e   operator;
    alu_cfg_pkg::operand_u operand_a;
    alu_cfg_pkg::operand_u operand_b;
    alu_cfg_pkg::operand_u imm;

    // driving side
    modport src (
        output operator, operand_a, operand_b, imm
    );

    // consuming units
    modport unit (
        input operator, operand_a, operand_b, imm
    );

endinterface

//--- rtl/alu_op_pkg.sv
// --------------------
// ALU operator encoding
// helpers that group operators by class
// --------------------

package alu_op_pkg;

    typedef enum logic [5:0] {
        // adder
        ADD, SUB, ADDW, SUBW,
        // logic
        ANDL, ORL, XORL,
        // shifts
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // set-less-than
        SLTS, SLTU,
        // branch compares
        EQ, NE, LTS, LTU, GES, GEU,
        // turbo decoder arithmetic
        TB_MAX, TB_ADDS, TB_SUBS, TB_DIV_ADD, TB_DIV_SUB, TB_SB_SAT,
        TB_MAXPM, TB_ACCUPP, TB_ACCUPM, TB_BLEND, TB_SCALE, TB_SHUFFLE
    } alu_op_e;

    // 32-bit operations, result sign-extended from bit 31
    function automatic logic is_word_op(alu_op_e op);
        return op inside {ADDW, SUBW, SLLW, SRLW, SRAW};
    endfunction

    // compares that treat the operands as signed
    function automatic logic is_signed_cmp(alu_op_e op);
        return op inside {SLTS, LTS, GES};
    endfunction

    // four-lane SIMD operations
    function automatic logic is_turbo_op(alu_op_e op);
        return op inside {TB_MAX, TB_ADDS, TB_SUBS, TB_DIV_ADD, TB_DIV_SUB,
                          TB_SB_SAT, TB_MAXPM, TB_ACCUPP, TB_ACCUPM,
                          TB_BLEND, TB_SCALE, TB_SHUFFLE};
    endfunction

endpackage

//--- rtl/alu_cfg_pkg.sv
// --------------------
// datapath configuration of the ALU
// widths, turbo lane geometry and shuffle encoding
// operand word type, readable as a scalar or as SIMD lanes
// --------------------

package alu_cfg_pkg;

    // datapath widths
    localparam int XLEN         = 64;
    localparam int WORD_W       = 32;
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_WORD_W = 5;

    // turbo lane geometry
    localparam int LANE_W = 8;
    localparam int LANES  = 4;
    localparam int SIMD_W = LANE_W * LANES;

    // sub-saturate clamp, symmetric around zero
    localparam int SAT_LIMIT = 63;

    // shuffle control held in each lane of operand b
    localparam int SHFL_IDX_W    = 4;
    localparam int SHFL_ZERO_KEY = 1;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic signed [LANE_W-1:0] lane_t;
    typedef lane_t [LANES-1:0] simd_vec_t;

    // scalar view or SIMD view of the same 64-bit operand
    typedef union packed {
        xlen_t scalar;
        struct packed {
            logic [XLEN-SIMD_W-1:0] upper;
            simd_vec_t              lanes;
        } simd;
    } operand_u;

endpackage
